/* design/cpu16_pkg.sv */
package cpu16_pkg;

	// instruction classes, top nibble of the word
	localparam logic [3:0] CLS_NOP    = 4'h0; // also ret and inc/dec multiple
	localparam logic [3:0] CLS_IMM    = 4'h1; // high immediate prefix
	localparam logic [3:0] CLS_ALU_RR = 4'h2;
	localparam logic [3:0] CLS_ALU_RI = 4'h3;
	localparam logic [3:0] CLS_BRANCH = 4'h4;
	localparam logic [3:0] CLS_MEM    = 4'h5;

	// class 0 sub-codes in bits 11:8
	localparam logic [3:0] SUB_RET  = 4'h1; // bit 0 picks iret
	localparam logic [3:0] SUB_INCM = 4'h2; // mask in bits 6:0, active low
	localparam logic [3:0] SUB_DECM = 4'h3;

	localparam logic [2:0] COND_Z  = 3'd0;
	localparam logic [2:0] COND_NZ = 3'd1;
	localparam logic [2:0] COND_S  = 3'd2;
	localparam logic [2:0] COND_NS = 3'd3;
	localparam logic [2:0] COND_C  = 3'd4;
	localparam logic [2:0] COND_NC = 3'd5;
	localparam logic [2:0] COND_A  = 3'd6; // always
	localparam logic [2:0] COND_BL = 3'd7; // always, with link

	localparam logic [3:0] ALU_MOV = 4'h0; // passes b
	localparam logic [3:0] ALU_ADD = 4'h1;
	localparam logic [3:0] ALU_ADC = 4'h2;
	localparam logic [3:0] ALU_SUB = 4'h3; // carry is borrow
	localparam logic [3:0] ALU_SBB = 4'h4;
	localparam logic [3:0] ALU_AND = 4'h5;
	localparam logic [3:0] ALU_OR  = 4'h6;
	localparam logic [3:0] ALU_XOR = 4'h7;
	localparam logic [3:0] ALU_NOT = 4'h8; // ~b
	localparam logic [3:0] ALU_BIC = 4'h9; // a & ~b
	localparam logic [3:0] ALU_SHL = 4'hA;
	localparam logic [3:0] ALU_SHR = 4'hB;
	localparam logic [3:0] ALU_ASR = 4'hC;
	localparam logic [3:0] ALU_ROL = 4'hD;
	localparam logic [3:0] ALU_ROR = 4'hE;
	localparam logic [3:0] ALU_NOP = 4'hF; // passes b, flags held

	localparam logic [2:0] REG_PC  = 3'd7;
	localparam logic [2:0] REG_LR  = 3'd6;
	localparam logic [2:0] REG_ILR = 3'd5;

	localparam logic [15:0] NOP_WORD = 16'h0000;

	// one instruction word, three ways of reading it
	typedef union packed {
		struct packed {
			logic [3:0] cls;
			logic [3:0] op;      // alu op or class 0 sub-code
			logic       store_n; // 1 = flags only
			logic [2:0] dest;
			logic [3:0] imm_src; // low imm or src in 2:0
		} alu_view;
		struct packed {
			logic [3:0] cls;
			logic       rsvd_hi;
			logic       post_dec_n;
			logic       post_inc_n;
			logic       dir;      // 1 = store
			logic       rsvd_mid;
			logic [2:0] index;    // address register
			logic       rsvd_lo;
			logic [2:0] data_reg; // store source or load dest
		} mem_view;
		struct packed {
			logic [3:0] cls;
			logic       rsvd_hi;
			logic [2:0] cond;
			logic [3:0] rsvd_lo;
			logic [3:0] imm;      // low target bits
		} branch_view;
	} instr_u;

endpackage

/* design/cpu16_ctrl_if.sv */
`timescale 1ns/1ps

interface cpu16_ctrl_if #(
	parameter int DATA_W = 16
);
	logic [7:0]        ld_alu_b;   // load from alu result
	logic [7:0]        ld_mem_b;   // load from memory
	logic [7:0]        ld_p_b;     // load from pout
	logic [7:0]        inc_b;
	logic [7:0]        dec_b;
	logic [2:0]        a_sel;      // alu a source
	logic [2:0]        b_sel;      // alu b source
	logic [2:0]        m_sel;      // store data source
	logic [2:0]        maddr_sel;  // address source
	logic              m_en_b;     // store data enable
	logic              b_from_p_b; // b bus from pout
	logic [DATA_W-1:0] pout;       // prefix plus low imm

	modport ctrl (
		output ld_alu_b, ld_mem_b, ld_p_b, inc_b, dec_b,
		output a_sel, b_sel, m_sel, maddr_sel,
		output m_en_b, b_from_p_b, pout
	);

	modport regs (
		input ld_alu_b, ld_mem_b, ld_p_b, inc_b, dec_b,
		input a_sel, b_sel, m_sel, maddr_sel,
		input m_en_b, b_from_p_b, pout
	);

endinterface

/* design/cpu16_alu.sv */
`timescale 1ns/1ps

module cpu16_alu #(
	parameter int DATA_W = 16
) (
	input  logic              CLK,
	input  logic              RSTb,
	input  logic [3:0]        op,
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	output logic [DATA_W-1:0] result,
	output logic              c,
	output logic              z,
	output logic              s
);
	logic [DATA_W:0] wide; // carry out on top

	always_comb begin
		case (op)
			cpu16_pkg::ALU_MOV: wide = {c, b};
			cpu16_pkg::ALU_ADD: wide = {1'b0, a} + {1'b0, b};
			cpu16_pkg::ALU_ADC: wide = {1'b0, a} + {1'b0, b} + (DATA_W+1)'(c);
			cpu16_pkg::ALU_SUB: wide = {1'b0, a} - {1'b0, b}; // top bit = borrow
			cpu16_pkg::ALU_SBB: wide = {1'b0, a} - {1'b0, b} - (DATA_W+1)'(c);
			cpu16_pkg::ALU_AND: wide = {c, a & b};
			cpu16_pkg::ALU_OR:  wide = {c, a | b};
			cpu16_pkg::ALU_XOR: wide = {c, a ^ b};
			cpu16_pkg::ALU_NOT: wide = {c, ~b};
			cpu16_pkg::ALU_BIC: wide = {c, a & ~b};
			cpu16_pkg::ALU_SHL: wide = {a, 1'b0};                       // msb out
			cpu16_pkg::ALU_SHR: wide = {a[0], 1'b0, a[DATA_W-1:1]};     // lsb out
			cpu16_pkg::ALU_ASR: wide = {a[0], a[DATA_W-1], a[DATA_W-1:1]};
			cpu16_pkg::ALU_ROL: wide = {a[DATA_W-1], a[DATA_W-2:0], a[DATA_W-1]};
			cpu16_pkg::ALU_ROR: wide = {a[0], a[0], a[DATA_W-1:1]};
			default:            wide = {c, b}; // nop move
		endcase
	end

	assign result = wide[DATA_W-1:0];

	// flags for a branch in the next stage0
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			c <= 1'b0;
			z <= 1'b0;
			s <= 1'b0;
		end else if (op != cpu16_pkg::ALU_NOP) begin
			c <= wide[DATA_W]; // logic ops carry the old c through
			z <= (result == '0);
			s <= result[DATA_W-1];
		end
	end

endmodule

/* design/cpu16_regfile.sv */
`timescale 1ns/1ps

module cpu16_regfile #(
	parameter int DATA_W = 16
) (
	input  logic              CLK,
	input  logic              RSTb,
	cpu16_ctrl_if.regs        ctl,
	input  logic [DATA_W-1:0] alu_result,
	input  logic [DATA_W-1:0] mem_rdata,
	output logic [DATA_W-1:0] a_bus,
	output logic [DATA_W-1:0] b_bus,
	output logic [DATA_W-1:0] mem_wdata,
	output logic [DATA_W-1:0] mem_addr
);
	logic [DATA_W-1:0] rf [8]; // r7 pc, r6 lr, r5 ilr

	always_ff @(posedge CLK) begin
		for (int i = 0; i < 8; i++) begin
			if (!ctl.ld_alu_b[i])
				rf[i] <= alu_result;
			else if (!ctl.ld_mem_b[i])
				rf[i] <= mem_rdata;
			else if (!ctl.ld_p_b[i])
				rf[i] <= ctl.pout;
			else if (!ctl.inc_b[i])
				rf[i] <= rf[i] + 1'b1;
			else if (!ctl.dec_b[i])
				rf[i] <= rf[i] - 1'b1;
		end
		if (!RSTb)
			rf[cpu16_pkg::REG_PC] <= '0; // start fetching at 0
	end

	assign a_bus     = rf[ctl.a_sel];
	assign b_bus     = ctl.b_from_p_b ? rf[ctl.b_sel] : ctl.pout; // imm path
	assign mem_wdata = ctl.m_en_b ? '0 : rf[ctl.m_sel];          // zero when idle
	assign mem_addr  = rf[ctl.maddr_sel];

	// Controller decode never aims two load sources at one register.
	a_one_load: assert property (@(posedge CLK) disable iff (!RSTb)
		((~ctl.ld_alu_b & ~ctl.ld_mem_b) | (~ctl.ld_alu_b & ~ctl.ld_p_b)
			| (~ctl.ld_mem_b & ~ctl.ld_p_b)) == 8'h00);

endmodule

/* design/cpu16_ctrl.sv */
`timescale 1ns/1ps

module cpu16_ctrl #(
	parameter int DATA_W = 16
) (
	input  logic        CLK,
	input  logic        RSTb,
	input  logic [15:0] fetch_word, // mem[r7] in a fetch cycle
	input  logic        c,
	input  logic        z,
	input  logic        s,
	output logic [3:0]  alu_op,
	output logic        mem_oe_b,
	output logic        mem_wr_b,
	cpu16_ctrl_if.ctrl  ctl
);
	localparam int PFX_W = DATA_W - 4;

	cpu16_pkg::instr_u stage0;       // executing now
	cpu16_pkg::instr_u stage0_next;
	cpu16_pkg::instr_u stage1;       // memory access and link fixup
	logic              stall;
	logic              stall_next;
	logic              delay_slot;
	logic              delay_slot_next;
	logic [PFX_W-1:0]  imm_prefix;
	logic [PFX_W-1:0]  imm_prefix_next;
	logic [3:0]        imm4;         // low pout nibble
	logic              taken;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			stage0     <= cpu16_pkg::NOP_WORD;
			stage1     <= cpu16_pkg::NOP_WORD;
			stall      <= 1'b1; // no fetch until a cycle after release
			delay_slot <= 1'b0;
			imm_prefix <= '0;
		end else begin
			stage0     <= stage0_next;
			stage1     <= stage0;
			stall      <= stall_next;
			delay_slot <= delay_slot_next;
			imm_prefix <= imm_prefix_next;
		end
	end

	// branch condition against live flags
	always_comb begin
		case (stage0.branch_view.cond)
			cpu16_pkg::COND_Z:  taken = z;
			cpu16_pkg::COND_NZ: taken = !z;
			cpu16_pkg::COND_S:  taken = s;
			cpu16_pkg::COND_NS: taken = !s;
			cpu16_pkg::COND_C:  taken = c;
			cpu16_pkg::COND_NC: taken = !c;
			cpu16_pkg::COND_A:  taken = 1'b1;
			cpu16_pkg::COND_BL: taken = 1'b1;
		endcase
	end

	always_comb begin
		alu_op          = cpu16_pkg::ALU_NOP;
		imm4            = 4'h0;
		ctl.ld_alu_b    = 8'hff;
		ctl.ld_mem_b    = 8'hff;
		ctl.ld_p_b      = 8'hff;
		ctl.inc_b       = 8'hff;
		ctl.dec_b       = 8'hff;
		ctl.a_sel       = 3'd0;
		ctl.b_sel       = 3'd0;
		ctl.m_sel       = 3'd0;
		ctl.maddr_sel   = cpu16_pkg::REG_PC;
		ctl.m_en_b      = 1'b1;
		ctl.b_from_p_b  = 1'b1;
		mem_oe_b        = 1'b1;
		mem_wr_b        = 1'b1;
		stall_next      = 1'b0;
		delay_slot_next = 1'b0;
		imm_prefix_next = '0; // prefix lives for one instruction
		stage0_next     = cpu16_pkg::NOP_WORD;

		// fetch at r7 and bump it
		if (!stall) begin
			mem_oe_b                      = 1'b0;
			ctl.inc_b[cpu16_pkg::REG_PC]  = 1'b0;
			if (!delay_slot)
				stage0_next = fetch_word; // target word is dropped in the delay slot
		end

		// stage 0 decode
		case (stage0.alu_view.cls)
			cpu16_pkg::CLS_NOP: begin
				case (stage0.alu_view.op)
					cpu16_pkg::SUB_RET: begin
						ctl.b_sel = stage0.alu_view.imm_src[0] ? cpu16_pkg::REG_ILR
							: cpu16_pkg::REG_LR;
						ctl.ld_alu_b[cpu16_pkg::REG_PC] = 1'b0; // r7 <= lr via nop move
						ctl.inc_b[cpu16_pkg::REG_PC]    = 1'b1;
						mem_oe_b                        = 1'b1;
						stage0_next                     = cpu16_pkg::NOP_WORD;
						delay_slot_next                 = 1'b1;
					end
					cpu16_pkg::SUB_INCM:
						ctl.inc_b[6:0] = {stage0.alu_view.dest, stage0.alu_view.imm_src};
					cpu16_pkg::SUB_DECM:
						ctl.dec_b[6:0] = {stage0.alu_view.dest, stage0.alu_view.imm_src};
					default: ;
				endcase
			end
			cpu16_pkg::CLS_IMM:
				imm_prefix_next = PFX_W'(stage0[11:0]);
			cpu16_pkg::CLS_ALU_RR: begin
				alu_op    = stage0.alu_view.op;
				ctl.a_sel = stage0.alu_view.dest;
				ctl.b_sel = stage0.alu_view.imm_src[2:0];
				if (!stage0.alu_view.store_n)
					ctl.ld_alu_b[stage0.alu_view.dest] = 1'b0;
			end
			cpu16_pkg::CLS_ALU_RI: begin
				alu_op         = stage0.alu_view.op;
				ctl.a_sel      = stage0.alu_view.dest;
				ctl.b_from_p_b = 1'b0; // b = prefix : imm
				imm4           = stage0.alu_view.imm_src;
				if (!stage0.alu_view.store_n)
					ctl.ld_alu_b[stage0.alu_view.dest] = 1'b0;
			end
			cpu16_pkg::CLS_BRANCH: begin
				if (taken) begin
					imm4                           = stage0.branch_view.imm;
					ctl.ld_p_b[cpu16_pkg::REG_PC]  = 1'b0; // r7 <= pout
					ctl.inc_b[cpu16_pkg::REG_PC]   = 1'b1;
					mem_oe_b                       = 1'b1;
					stage0_next                    = cpu16_pkg::NOP_WORD;
					delay_slot_next                = 1'b1;
					if (stage0.branch_view.cond == cpu16_pkg::COND_BL) begin
						ctl.b_sel                        = cpu16_pkg::REG_PC;
						ctl.ld_alu_b[cpu16_pkg::REG_LR]  = 1'b0; // lr <= pc
					end
				end
			end
			cpu16_pkg::CLS_MEM: begin
				// bus is kept free for the access next cycle
				stall_next                    = 1'b1;
				ctl.inc_b[cpu16_pkg::REG_PC]  = 1'b1;
				mem_oe_b                      = 1'b1;
				stage0_next                   = cpu16_pkg::NOP_WORD;
			end
			default: ;
		endcase

		// stage 1
		case (stage1.alu_view.cls)
			cpu16_pkg::CLS_BRANCH: begin
				if (stage1.branch_view.cond == cpu16_pkg::COND_BL)
					ctl.dec_b[cpu16_pkg::REG_LR] = 1'b0; // ret adds it back in the slot
			end
			cpu16_pkg::CLS_MEM: begin
				ctl.maddr_sel                       = stage1.mem_view.index;
				ctl.inc_b[stage1.mem_view.index]    = stage1.mem_view.post_inc_n;
				ctl.dec_b[stage1.mem_view.index]    = stage1.mem_view.post_dec_n;
				if (stage1.mem_view.dir) begin
					ctl.m_en_b = 1'b0;
					ctl.m_sel  = stage1.mem_view.data_reg;
					mem_wr_b   = 1'b0; // fetch is held off by the stall
				end else begin
					mem_oe_b                              = 1'b0;
					ctl.ld_mem_b[stage1.mem_view.data_reg] = 1'b0;
				end
			end
			default: ;
		endcase

		ctl.pout = {imm_prefix, imm4};
	end

	a_strobes: assert property (@(posedge CLK) disable iff (!RSTb)
		!(!mem_oe_b && !mem_wr_b));

endmodule

/* design/cpu16_top.sv */
`timescale 1ns/1ps

module cpu16_top #(
	parameter int DATA_W = 16
) (
	input  logic              CLK,
	input  logic              RSTb,
	output logic [DATA_W-1:0] mem_addr,
	input  logic [DATA_W-1:0] mem_rdata,
	output logic [DATA_W-1:0] mem_wdata, // valid while mem_wr_b low
	output logic              mem_oe_b,
	output logic              mem_wr_b
);
	logic [3:0]        alu_op;
	logic [DATA_W-1:0] a_bus;
	logic [DATA_W-1:0] b_bus;
	logic [DATA_W-1:0] alu_result;
	logic              c;
	logic              z;
	logic              s;

	cpu16_ctrl_if #(.DATA_W(DATA_W)) ctl_bus ();

	cpu16_ctrl #(.DATA_W(DATA_W)) u_ctrl (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.fetch_word (mem_rdata[15:0]), // instruction words are 16 bits
		.c          (c),
		.z          (z),
		.s          (s),
		.alu_op     (alu_op),
		.mem_oe_b   (mem_oe_b),
		.mem_wr_b   (mem_wr_b),
		.ctl        (ctl_bus.ctrl)
	);

	cpu16_regfile #(.DATA_W(DATA_W)) u_regfile (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.ctl        (ctl_bus.regs),
		.alu_result (alu_result),
		.mem_rdata  (mem_rdata),
		.a_bus      (a_bus),
		.b_bus      (b_bus),
		.mem_wdata  (mem_wdata),
		.mem_addr   (mem_addr)
	);

	cpu16_alu #(.DATA_W(DATA_W)) u_alu (
		.CLK    (CLK),
		.RSTb   (RSTb),
		.op     (alu_op),
		.a      (a_bus),
		.b      (b_bus),
		.result (alu_result),
		.c      (c),
		.z      (z),
		.s      (s)
	);

endmodule

/* tests/cpu16_tb.sv */
`timescale 1ns/1ps

module cpu16_tb;
	localparam int                DATA_W     = 16;
	localparam int                MEM_WORDS  = 256;
	localparam int                LIST_BASE  = 256;       // expected list in the image
	localparam logic [15:0]       MARKER     = 16'hE5A7;
	localparam logic [DATA_W-1:0] DONE_ADDR  = 'h00ff;    // program ends with a store here

	logic              CLK;
	logic              RSTb;
	logic [DATA_W-1:0] mem_addr;
	logic [DATA_W-1:0] mem_rdata;
	logic [DATA_W-1:0] mem_wdata;
	logic              mem_oe_b;
	logic              mem_wr_b;

	logic [15:0]       image [512];     // program, then marker, count, pairs
	logic [DATA_W-1:0] mem [MEM_WORDS];
	int                n_exp;
	int                n_seen;
	int                prog_len;
	int                limit;
	int                cycles;
	int                value_errs;
	int                other_errs;
	bit                done;
	bit                fetch_seen;

	cpu16_top #(.DATA_W(DATA_W)) UUT (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.mem_addr  (mem_addr),
		.mem_rdata (mem_rdata),
		.mem_wdata (mem_wdata),
		.mem_oe_b  (mem_oe_b),
		.mem_wr_b  (mem_wr_b)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	assign mem_rdata = mem[mem_addr[7:0]]; // async read, 256 words

	always @(posedge CLK) begin
		if (!mem_wr_b)
			mem[mem_addr[7:0]] <= mem_wdata;
	end

	task automatic compare_strobe(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
			value_errs++;
		end
	endtask

	task automatic compare_fetch_addr(input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t: first fetch from %h, expected %h", $time, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_store_addr(input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t: store %0d address %h, expected %h",
				$time, n_seen, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_store_data(input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t: store %0d data %h, expected %h",
				$time, n_seen, got, exp);
			value_errs++;
		end
	endtask

	initial begin
		int i;
		RSTb       = 1'b0;
		value_errs = 0;
		other_errs = 0;
		n_seen     = 0;
		cycles     = 0;
		done       = 1'b0;
		fetch_seen = 1'b0;
		for (i = 0; i < 512; i++)
			image[i] = '0;
		$readmemh("tests/cpu16_testdata.hex", image);
		prog_len = 0;
		for (i = 0; i < MEM_WORDS; i++) begin
			mem[i] <= image[i];
			if (image[i] != '0)
				prog_len = i + 1; // last used word
		end
		if (image[LIST_BASE] != MARKER) begin
			$display("testdata has no marker word in front of the expected stores");
			other_errs++;
		end
		n_exp = image[LIST_BASE+1];
		limit = 4 * prog_len + 64;

		@(posedge CLK); // first edge loads the reset state
		for (i = 1; i < 16; i++) begin
			@(negedge CLK);
			compare_strobe(mem_oe_b, 1'b1, "mem_oe_b in reset");
			compare_strobe(mem_wr_b, 1'b1, "mem_wr_b in reset");
			@(posedge CLK);
		end
		#1 RSTb = 1'b1;

		while (!done && cycles < limit) begin
			@(negedge CLK); // strobes and buses settled here
			cycles++;
			if (!fetch_seen && !mem_oe_b) begin
				fetch_seen = 1'b1;
				compare_fetch_addr(mem_addr, '0);
			end
			if (!mem_wr_b) begin
				if (n_seen < n_exp) begin
					check_store_addr(mem_addr, image[LIST_BASE+2+2*n_seen]);
					check_store_data(mem_wdata, image[LIST_BASE+3+2*n_seen]);
				end else begin
					$display("unexpected extra store at %0t to address %h", $time, mem_addr);
					other_errs++;
				end
				n_seen++;
				if (mem_addr == DONE_ADDR)
					done = 1'b1;
			end
		end

		if (!done) begin
			$display("timeout: program did not finish");
			other_errs++;
		end
		if (n_seen < n_exp) begin
			$display("stores missing, saw %0d of %0d", n_seen, n_exp);
			other_errs++;
		end
		$display("errors: %0d value, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* tests/cpu16_testdata.hex */
// program words from address 0; at @100 the marker word E5A7, then the store count,
// then one expected store per line: address data
@000
1008 3040 1123 3004 3015 2101 5540  // r4 pointer 0x80, r0 0x1234, r1 5, add, store
1FFF 331F 5541 2701 3580 5540       // sub with prefix sets c, xor, and with store_n
1001 4000 5540 5540                 // bz taken, both stores skipped
4100 5541                           // bnz not taken
4500 1001 4408 5540 5540 5540       // bnc not taken, bc taken
1FFF 302F 4300 1002 4202            // r2 = ffff sets s, bns not taken, bs taken
5540 5540 5540 5540 5540            // skipped by bs
5542
1800 3030 2131 4400 5543            // c clear with s set, bc not taken
1004 470F                           // bl to 0x4f
5540                                // resume point after ret
1008 3050 5451 5452 5541 5542       // loads with post-increment, stored back
5253 5250 5343 5340                 // post-decrement loads and stores
0278 0376 5540 5541 5542 5543       // incm r0-r2, decm r0 r3
100F 304F 5742                      // last store at 0xff
1003 460E                           // halt loop
@050
5546 0100 5540 5540                 // subroutine stores lr, returns
@100
E5A7 0011
0080 1239
0081 0006
0082 123F
0083 0006
0084 FFFF
0085 8006
0086 002A
0087 123F
0088 1239
0089 0006
008A 123F
0089 0006
0088 0006
0089 123A
008A 0007
008B 123E
00FF 0007

/* cpu16_top.f */
design/cpu16_pkg.sv
design/cpu16_ctrl_if.sv
design/cpu16_alu.sv
design/cpu16_regfile.sv
design/cpu16_ctrl.sv
design/cpu16_top.sv
tests/cpu16_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the cpu16 testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cpu16_tb \
	-f cpu16_top.f -o cpu16_sim > build.log 2>&1 \
	&& ./obj_dir/cpu16_sim > sim.log 2>&1 \
	|| { echo "build or run failed, see build.log and sim.log"; exit 1; }
grep -q "^PASS: all tests$" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
